// File: src.f
+incdir+tests
verilog/blimp_isa_pkg.sv
verilog/blimp_uarch_pkg.sv
verilog/fetch_unit.sv
verilog/decode_issue_unit.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/writeback_commit_unit.sv
verilog/blimp_core.sv
tests/blimp_core_tb.sv

// File: tests/blimp_core_tb_tasks.svh
// In-order reference over 32 registers with no timing; x0 is never written and reads zero
`ifndef BLIMP_CORE_TB_TASKS_SVH
`define BLIMP_CORE_TB_TASKS_SVH

  // ----------------------------------------------------------
  // Encoders and golden model
  // ----------------------------------------------------------

  function automatic logic [inst_w-1:0] enc_r(input opcode_e op, input int rd,
                                              input int rs1, input int rs2);
    logic [inst_w-1:0] w;
    w = '0;
    w[op_lsb +: op_w]        = op;
    w[rd_lsb +: reg_addr_w]  = reg_addr_w'(rd);
    w[rs1_lsb +: reg_addr_w] = reg_addr_w'(rs1);
    w[rs2_lsb +: reg_addr_w] = reg_addr_w'(rs2);
    return w;
  endfunction

  function automatic logic [inst_w-1:0] enc_i(input int rd, input int rs1, input int imm);
    logic [inst_w-1:0] w;
    w = '0;
    w[op_lsb +: op_w]        = OP_ADDI;
    w[rd_lsb +: reg_addr_w]  = reg_addr_w'(rd);
    w[rs1_lsb +: reg_addr_w] = reg_addr_w'(rs1);
    w[imm_lsb +: imm_w]      = imm_w'(imm);  // Low 12 bits, two's complement
    return w;
  endfunction

  function automatic void build_expected();
    logic [xlen-1:0]       regs [num_arch_regs];
    logic [inst_w-1:0]     w;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       a;
    logic [xlen-1:0]       b;
    logic [xlen-1:0]       res;
    exp_pc.delete();
    exp_waddr.delete();
    exp_wen.delete();
    exp_wdata.delete();
    foreach (regs[r])
      regs[r] = '0;
    foreach (prog_q[i]) begin
      w  = prog_q[i];
      rd = w[rd_lsb +: reg_addr_w];
      a  = regs[w[rs1_lsb +: reg_addr_w]];
      b  = regs[w[rs2_lsb +: reg_addr_w]];
      case (w[op_lsb +: op_w])
        OP_ADDI: res = a + {{(xlen-imm_w){w[imm_lsb+imm_w-1]}}, w[imm_lsb +: imm_w]};
        OP_MUL:  res = a * b;  // Low word of the product
        default: res = a + b;
      endcase
      if (rd != '0)
        regs[rd] = res;
      exp_pc.push_back(xlen'(i) << 2);
      exp_waddr.push_back(rd);
      exp_wen.push_back(rd != '0);
      exp_wdata.push_back(res);
    end
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic compare_data(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                              input string what);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_addr(input logic [reg_addr_w-1:0] got,
                              input logic [reg_addr_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  // ----------------------------------------------------------
  // Directed and random tests
  // ----------------------------------------------------------

  task automatic test_reset_state();
    prog_q.delete();
    prog_q.push_back(enc_i(1, 0, 5));
    prog_q.push_back(enc_i(2, 0, 7));
    prog_q.push_back(enc_r(OP_ADD, 3, 1, 2));
    run_program("reset_state");  // First beat must carry pc 0
  endtask

  task automatic test_raw_chain();
    prog_q.delete();
    prog_q.push_back(enc_i(1, 0, 1));
    prog_q.push_back(enc_i(2, 1, 2));         // RAW on x1
    prog_q.push_back(enc_r(OP_ADD, 3, 2, 1));
    prog_q.push_back(enc_r(OP_ADD, 4, 3, 3));
    prog_q.push_back(enc_i(4, 4, -3));        // RAW and WAW on x4
    prog_q.push_back(enc_r(OP_ADD, 5, 4, 2));
    run_program("raw_chain");
  endtask

  task automatic test_mul_order();
    prog_q.delete();
    prog_q.push_back(enc_i(1, 0, 12));
    prog_q.push_back(enc_i(2, 0, -7));
    prog_q.push_back(enc_r(OP_MUL, 3, 1, 2));  // Finishes after the adds behind it
    prog_q.push_back(enc_i(4, 0, 100));
    prog_q.push_back(enc_r(OP_ADD, 5, 1, 2));
    prog_q.push_back(enc_i(6, 0, 1));
    prog_q.push_back(enc_r(OP_ADD, 7, 6, 6));
    run_program("mul_order");
  endtask

  task automatic test_mul_waw();
    prog_q.delete();
    prog_q.push_back(enc_i(1, 0, 3));
    prog_q.push_back(enc_r(OP_MUL, 2, 1, 1));
    prog_q.push_back(enc_r(OP_MUL, 3, 2, 2));  // Back-to-back dependent
    prog_q.push_back(enc_r(OP_MUL, 3, 3, 1));
    prog_q.push_back(enc_i(3, 0, -9));         // WAW behind a mul in flight
    prog_q.push_back(enc_r(OP_MUL, 4, 3, 2));
    prog_q.push_back(enc_i(5, 0, 2047));
    prog_q.push_back(enc_r(OP_MUL, 6, 5, 4));
    run_program("mul_waw");
  endtask

  task automatic test_x0_writes();
    prog_q.delete();
    prog_q.push_back(enc_i(1, 0, 4));
    prog_q.push_back(enc_i(0, 0, 123));
    prog_q.push_back(enc_r(OP_ADD, 0, 1, 1));
    prog_q.push_back(enc_r(OP_MUL, 0, 1, 1));
    prog_q.push_back(enc_r(OP_ADD, 2, 0, 1));  // x0 must still read zero
    prog_q.push_back(enc_i(3, 0, 0));
    prog_q.push_back(enc_r(OP_ADD, 4, 0, 0));
    run_program("x0_writes");
  endtask

  task automatic test_random_prog();
    int op_sel;
    int rd;
    int rs1;
    int rs2;
    prog_q.delete();
    repeat (40) begin
      op_sel = $urandom_range(2, 0);
      rd     = $urandom_range(7, 0);  // Few registers, so hazards are common
      rs1    = $urandom_range(7, 0);
      rs2    = $urandom_range(7, 0);
      if (op_sel == 0)
        prog_q.push_back(enc_r(OP_ADD, rd, rs1, rs2));
      else if (op_sel == 1)
        prog_q.push_back(enc_i(rd, rs1, $urandom_range(4095, 0)));
      else
        prog_q.push_back(enc_r(OP_MUL, rd, rs1, rs2));
    end
    run_program("random_prog");
  endtask

`endif

// File: tests/blimp_core_tb.sv
// Only the first program-length commits of each run are checked; the padding nops after them are ignored
`timescale 1ns/1ps

module blimp_core_tb;

  import blimp_isa_pkg::*;

  localparam int clk_period  = 100;
  localparam int total_insts = 71;  // Sum of all program lengths below
  localparam int mem_words   = 64;

  logic                  clk;
  logic                  rst;
  logic [inst_w-1:0]     imem_data;
  logic [xlen-1:0]       imem_addr;
  logic                  trace_val;
  logic [xlen-1:0]       trace_pc;
  logic [reg_addr_w-1:0] trace_waddr;
  logic [xlen-1:0]       trace_wdata;
  logic                  trace_wen;

  logic [inst_w-1:0] imem [mem_words];
  logic [inst_w-1:0] prog_q [$];  // Program being built by a test
  int                prog_len;

  // Expected commit list, one entry per instruction
  logic [xlen-1:0]       exp_pc    [$];
  logic [reg_addr_w-1:0] exp_waddr [$];
  logic                  exp_wen   [$];
  logic [xlen-1:0]       exp_wdata [$];

  int err_count;
  int tests_run;
  int tests_failed;
  int seed;

  initial clk = 1'b0;
  always #(clk_period/2) clk = ~clk;

  blimp_core DUT (.*);

  // Word address in bits 7:2; beyond the program the all-zero add x0,x0,x0
  assign imem_data = ((imem_addr >> 2) < prog_len) ? imem[imem_addr[7:2]] : '0;

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------

  initial begin
    #(total_insts * 20 * clk_period);
    $display("timeout: the core stopped committing, run aborted at %0t", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

  `include "blimp_core_tb_tasks.svh"

  // Load prog_q, reset the core, then walk the trace against the model
  task automatic run_program(input string name);
    int n;
    int idx;
    int cycles;
    int errs_before;
    errs_before = err_count;
    @(posedge clk);
    rst <= 1'b1;
    foreach (prog_q[i])
      imem[i] <= prog_q[i];
    prog_len <= prog_q.size();
    build_expected();
    n = exp_pc.size();
    @(posedge clk);
    @(negedge clk);
    compare_flag(trace_val, 1'b0, $sformatf("%s trace_val in reset", name));
    @(posedge clk);
    rst    <= 1'b0;  // Held for two cycles
    idx    = 0;
    cycles = 0;
    while (idx < n && cycles < n * 16) begin
      @(negedge clk);  // Trace is steady mid-cycle
      cycles++;
      if (trace_val) begin
        compare_data(trace_pc, exp_pc[idx], $sformatf("%s commit %0d pc", name, idx));
        compare_addr(trace_waddr, exp_waddr[idx], $sformatf("%s commit %0d waddr", name, idx));
        compare_flag(trace_wen, exp_wen[idx], $sformatf("%s commit %0d wen", name, idx));
        if (exp_wen[idx])  // Data of an x0 write is never architectural
          compare_data(trace_wdata, exp_wdata[idx], $sformatf("%s commit %0d wdata", name, idx));
        idx++;
      end
    end
    if (idx < n) begin
      $display("%s: only %0d of %0d instructions committed in time", name, idx, n);
      err_count++;
    end
    tests_run++;
    if (err_count != errs_before)
      tests_failed++;
    $display("%s: %0d commits checked, %s", name, idx,
             (err_count == errs_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    rst          = 1'b1;
    prog_len     = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = $urandom(73743);  // One seed for the whole run
    foreach (imem[i])
      imem[i] = '0;

    test_reset_state();
    test_raw_chain();
    test_mul_order();
    test_mul_waw();
    test_x0_writes();
    test_random_prog();

    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             err_count);
    if (tests_failed == 0 && err_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog/blimp_core.sv
// Top level; instruction memory must answer combinationally, no data memory and no control flow
`timescale 1ns/1ps

module blimp_core (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [blimp_isa_pkg::inst_w-1:0]     imem_data,
  output logic [blimp_isa_pkg::xlen-1:0]       imem_addr,
  output logic                                 trace_val,
  output logic [blimp_isa_pkg::xlen-1:0]       trace_pc,
  output logic [blimp_isa_pkg::reg_addr_w-1:0] trace_waddr,
  output logic [blimp_isa_pkg::xlen-1:0]       trace_wdata,
  output logic                                 trace_wen
);

  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;

  // ----------------------------------------------------------
  // Inter-unit wires
  // ----------------------------------------------------------

  // F/D
  logic              f_val, d_stall;
  logic [xlen-1:0]   f_pc;
  logic [inst_w-1:0] f_inst;

  // D/X
  logic                  alu_val, mul_val;
  opcode_e               alu_op;
  logic [xlen-1:0]       alu_a, alu_b, mul_a, mul_b;
  logic [seq_num_w-1:0]  alu_seq, mul_seq;
  logic [reg_addr_w-1:0] alu_waddr, mul_waddr;

  // Reorder buffer allocation
  logic                  alloc_val, rob_full;
  logic [xlen-1:0]       alloc_pc;
  logic [reg_addr_w-1:0] alloc_waddr;
  logic [seq_num_w-1:0]  alloc_seq;

  // X/W
  logic                  alu_x_val, mul_x_val;
  logic [seq_num_w-1:0]  alu_x_seq, mul_x_seq;
  logic [reg_addr_w-1:0] alu_x_waddr, mul_x_waddr;
  logic [xlen-1:0]       alu_x_data, mul_x_data;

  // Completion notices
  logic                  cmp0_val, cmp1_val;
  logic [reg_addr_w-1:0] cmp0_addr, cmp1_addr;
  logic [xlen-1:0]       cmp0_data, cmp1_data;

  // ----------------------------------------------------------
  // Units
  // ----------------------------------------------------------

  fetch_unit FU (.*);

  decode_issue_unit DIU (.*);

  alu_unit ALU_XU (
    .x_val   (alu_x_val),
    .x_seq   (alu_x_seq),
    .x_waddr (alu_x_waddr),
    .x_data  (alu_x_data),
    .*
  );

  mul_unit MUL_XU (
    .x_val   (mul_x_val),
    .x_seq   (mul_x_seq),
    .x_waddr (mul_x_waddr),
    .x_data  (mul_x_data),
    .*
  );

  writeback_commit_unit WCU (.*);

endmodule

// File: verilog/writeback_commit_unit.sv
// One commit per cycle from the head; the trace is registered, so it lags the commit by a cycle
`timescale 1ns/1ps

module writeback_commit_unit (
  input  logic                                  clk,
  input  logic                                  rst,
  // Allocation from decode
  input  logic                                  alloc_val,
  input  logic [blimp_isa_pkg::xlen-1:0]        alloc_pc,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]  alloc_waddr,
  output logic [blimp_uarch_pkg::seq_num_w-1:0] alloc_seq,
  output logic                                  rob_full,
  // Pipe results
  input  logic                                  alu_x_val,
  input  logic [blimp_uarch_pkg::seq_num_w-1:0] alu_x_seq,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]  alu_x_waddr,
  input  logic [blimp_isa_pkg::xlen-1:0]        alu_x_data,
  input  logic                                  mul_x_val,
  input  logic [blimp_uarch_pkg::seq_num_w-1:0] mul_x_seq,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]  mul_x_waddr,
  input  logic [blimp_isa_pkg::xlen-1:0]        mul_x_data,
  // Completion notices to decode
  output logic                                  cmp0_val,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]  cmp0_addr,
  output logic [blimp_isa_pkg::xlen-1:0]        cmp0_data,
  output logic                                  cmp1_val,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]  cmp1_addr,
  output logic [blimp_isa_pkg::xlen-1:0]        cmp1_data,
  // Instruction trace
  output logic                                  trace_val,
  output logic [blimp_isa_pkg::xlen-1:0]        trace_pc,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]  trace_waddr,
  output logic [blimp_isa_pkg::xlen-1:0]        trace_wdata,
  output logic                                  trace_wen
);

  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;

  logic [xlen-1:0]       pc_q    [rob_depth];
  logic [reg_addr_w-1:0] waddr_q [rob_depth];
  logic [xlen-1:0]       data_q  [rob_depth];
  logic [rob_depth-1:0]  done_q;
  logic [seq_num_w-1:0]  head, tail;
  logic [seq_num_w:0]    count;  // One wider, so full differs from empty
  logic                  commit;

  // Entry lies between head and tail
  function automatic logic in_rob(input logic [seq_num_w-1:0] s);
    logic [seq_num_w-1:0] ofs;
    ofs = s - head;
    return {1'b0, ofs} < count;
  endfunction

  assign alloc_seq = tail;
  assign rob_full  = (count == rob_depth);
  assign commit    = (count != '0) && done_q[head];

  // Notices go out the cycle the result appears
  assign cmp0_val  = alu_x_val;
  assign cmp0_addr = alu_x_waddr;
  assign cmp0_data = alu_x_data;
  assign cmp1_val  = mul_x_val;
  assign cmp1_addr = mul_x_waddr;
  assign cmp1_data = mul_x_data;

  // ----------------------------------------------------------
  // Pointers and done bits
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      done_q    <= '0;
      trace_val <= 1'b0;
    end else begin
      if (alloc_val) begin
        tail         <= tail + 1'b1;
        done_q[tail] <= 1'b0;
      end
      if (alu_x_val)
        done_q[alu_x_seq] <= 1'b1;
      if (mul_x_val)
        done_q[mul_x_seq] <= 1'b1;
      if (commit)
        head <= head + 1'b1;
      count     <= count + (seq_num_w+1)'(alloc_val) - (seq_num_w+1)'(commit);
      trace_val <= commit;
    end
  end

  // Entry payload and trace beat
  always_ff @(posedge clk) begin
    if (alloc_val) begin
      pc_q[tail]    <= alloc_pc;
      waddr_q[tail] <= alloc_waddr;
    end
    if (alu_x_val)
      data_q[alu_x_seq] <= alu_x_data;
    if (mul_x_val)
      data_q[mul_x_seq] <= mul_x_data;
    if (commit) begin
      trace_pc    <= pc_q[head];
      trace_waddr <= waddr_q[head];
      trace_wdata <= data_q[head];
      trace_wen   <= (waddr_q[head] != '0);  // x0 writes show up with wen low
    end
  end

  a_alu_cmp_live: assert property (@(posedge clk) disable iff (rst)
    alu_x_val |-> in_rob(alu_x_seq) && !done_q[alu_x_seq]);

  a_mul_cmp_live: assert property (@(posedge clk) disable iff (rst)
    mul_x_val |-> in_rob(mul_x_seq) && !done_q[mul_x_seq]);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    alloc_val && !commit |-> count < rob_depth);

endmodule

// File: verilog/mul_unit.sv
// Fixed four-stage pipe, low 32 bits of the product only; never stalls, one issue per cycle
`timescale 1ns/1ps

module mul_unit (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  mul_val,
  input  logic [blimp_isa_pkg::xlen-1:0]        mul_a,
  input  logic [blimp_isa_pkg::xlen-1:0]        mul_b,
  input  logic [blimp_uarch_pkg::seq_num_w-1:0] mul_seq,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]  mul_waddr,
  output logic                                  x_val,
  output logic [blimp_uarch_pkg::seq_num_w-1:0] x_seq,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]  x_waddr,
  output logic [blimp_isa_pkg::xlen-1:0]        x_data
);

  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;

  logic [mul_stages-1:0] vld;
  logic [seq_num_w-1:0]  seq_q   [mul_stages];
  logic [reg_addr_w-1:0] waddr_q [mul_stages];

  logic [xlen-1:0]   a_q, b_q;  // Stage 1
  logic [xlen-1:0]   pp_ll;     // Stage 2, low x low
  logic [xlen/2-1:0] pp_x;      // Stage 2, cross terms, low half only
  logic [xlen-1:0]   prod;      // Stage 3

  always_ff @(posedge clk) begin
    if (rst)
      vld <= '0;
    else
      vld <= {vld[mul_stages-2:0], mul_val};
  end

  // Tag shift register
  always_ff @(posedge clk) begin
    seq_q[0]   <= mul_seq;
    waddr_q[0] <= mul_waddr;
    for (int i = 1; i < mul_stages; i++) begin
      seq_q[i]   <= seq_q[i-1];
      waddr_q[i] <= waddr_q[i-1];
    end
  end

  // ----------------------------------------------------------
  // Datapath, one register per stage
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    a_q    <= mul_a;
    b_q    <= mul_b;
    pp_ll  <= a_q[xlen/2-1:0] * b_q[xlen/2-1:0];
    pp_x   <= a_q[xlen-1:xlen/2] * b_q[xlen/2-1:0]  // Truncates to 16 bits
            + a_q[xlen/2-1:0] * b_q[xlen-1:xlen/2];
    prod   <= pp_ll + {pp_x, {(xlen/2){1'b0}}};     // hi x hi drops out entirely
    x_data <= prod;
  end

  assign x_val   = vld[mul_stages-1];
  assign x_seq   = seq_q[mul_stages-1];
  assign x_waddr = waddr_q[mul_stages-1];

endmodule

// File: verilog/alu_unit.sv
// Single-cycle adder; decode has already swapped in the immediate for addi
`timescale 1ns/1ps

module alu_unit (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  alu_val,
  input  blimp_isa_pkg::opcode_e                alu_op,
  input  logic [blimp_isa_pkg::xlen-1:0]        alu_a,
  input  logic [blimp_isa_pkg::xlen-1:0]        alu_b,
  input  logic [blimp_uarch_pkg::seq_num_w-1:0] alu_seq,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]  alu_waddr,
  output logic                                  x_val,
  output logic [blimp_uarch_pkg::seq_num_w-1:0] x_seq,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]  x_waddr,
  output logic [blimp_isa_pkg::xlen-1:0]        x_data
);

  import blimp_isa_pkg::*;

  always_ff @(posedge clk) begin
    if (rst)
      x_val <= 1'b0;
    else
      x_val <= alu_val;
  end

  // Result register, tags ride along
  always_ff @(posedge clk) begin
    if (alu_val) begin
      x_seq   <= alu_seq;
      x_waddr <= alu_waddr;
      x_data  <= alu_a + alu_b;
    end
  end

  // Mul never comes this way
  a_alu_ops_only: assert property (@(posedge clk) disable iff (rst)
    alu_val |-> alu_op inside {OP_ADD, OP_ADDI});

endmodule

// File: verilog/decode_issue_unit.sv
// No renaming, so RAW and WAW hazards both stall; registers are written at completion, not commit
`timescale 1ns/1ps

module decode_issue_unit (
  input  logic                                   clk,
  input  logic                                   rst,
  // From fetch
  input  logic                                   f_val,
  input  logic [blimp_isa_pkg::xlen-1:0]         f_pc,
  input  logic [blimp_isa_pkg::inst_w-1:0]       f_inst,
  output logic                                   d_stall,
  // ALU issue
  output logic                                   alu_val,
  output blimp_isa_pkg::opcode_e                 alu_op,
  output logic [blimp_isa_pkg::xlen-1:0]         alu_a,
  output logic [blimp_isa_pkg::xlen-1:0]         alu_b,
  output logic [blimp_uarch_pkg::seq_num_w-1:0]  alu_seq,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]   alu_waddr,
  // Mul issue
  output logic                                   mul_val,
  output logic [blimp_isa_pkg::xlen-1:0]         mul_a,
  output logic [blimp_isa_pkg::xlen-1:0]         mul_b,
  output logic [blimp_uarch_pkg::seq_num_w-1:0]  mul_seq,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]   mul_waddr,
  // Reorder buffer allocation
  output logic                                   alloc_val,
  output logic [blimp_isa_pkg::xlen-1:0]         alloc_pc,
  output logic [blimp_isa_pkg::reg_addr_w-1:0]   alloc_waddr,
  input  logic [blimp_uarch_pkg::seq_num_w-1:0]  alloc_seq,
  input  logic                                   rob_full,
  // Completion notices, ALU then mul
  input  logic                                   cmp0_val,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]   cmp0_addr,
  input  logic [blimp_isa_pkg::xlen-1:0]         cmp0_data,
  input  logic                                   cmp1_val,
  input  logic [blimp_isa_pkg::reg_addr_w-1:0]   cmp1_addr,
  input  logic [blimp_isa_pkg::xlen-1:0]         cmp1_data
);

  import blimp_isa_pkg::*;
  import blimp_uarch_pkg::*;

  logic [xlen-1:0]          rf [num_arch_regs];
  logic [num_arch_regs-1:0] pending;  // Result still owed by a pipe

  opcode_e               op;
  pipe_e                 pipe;
  logic                  legal, uses_rs2, hazard, issue;
  logic [reg_addr_w-1:0] rd, rs1, rs2;
  logic [xlen-1:0]       imm, opnd_a, opnd_b;

  // Pending, unless its result arrives this very cycle
  function automatic logic busy(input logic [reg_addr_w-1:0] a);
    return pending[a] && !(cmp0_val && cmp0_addr == a) && !(cmp1_val && cmp1_addr == a);
  endfunction

  // Register read, completions written through
  function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_w-1:0] a);
    if (a == '0)
      return '0;
    if (cmp0_val && cmp0_addr == a)
      return cmp0_data;
    if (cmp1_val && cmp1_addr == a)
      return cmp1_data;
    return rf[a];
  endfunction

  // ----------------------------------------------------------
  // Decode, hazard check, issue
  // ----------------------------------------------------------

  always_comb begin
    op       = opcode_e'(f_inst[op_lsb +: op_w]);
    legal    = op inside {OP_ADD, OP_ADDI, OP_MUL};
    pipe     = (op == OP_MUL) ? PIPE_MUL : PIPE_ALU;  // Illegal ops go down the ALU as nops
    uses_rs2 = (op != OP_ADDI);
    rd       = legal ? f_inst[rd_lsb +: reg_addr_w] : '0;
    rs1      = f_inst[rs1_lsb +: reg_addr_w];
    rs2      = f_inst[rs2_lsb +: reg_addr_w];
    imm      = {{(xlen-imm_w){f_inst[imm_lsb+imm_w-1]}}, f_inst[imm_lsb +: imm_w]};

    // RAW on sources, WAW on rd
    hazard  = legal && (busy(rs1) || (uses_rs2 && busy(rs2)) || busy(rd));
    d_stall = f_val && (hazard || rob_full);
    issue   = f_val && !d_stall;

    opnd_a = legal ? read_reg(rs1) : '0;
    if (!legal)
      opnd_b = '0;
    else if (op == OP_ADDI)
      opnd_b = imm;  // ALU just adds
    else
      opnd_b = read_reg(rs2);

    alu_val   = issue && (pipe == PIPE_ALU);
    alu_op    = legal ? op : OP_ADD;
    alu_a     = opnd_a;
    alu_b     = opnd_b;
    alu_seq   = alloc_seq;  // Tail slot doubles as the tag
    alu_waddr = rd;

    mul_val   = issue && (pipe == PIPE_MUL);
    mul_a     = opnd_a;
    mul_b     = opnd_b;
    mul_seq   = alloc_seq;
    mul_waddr = rd;

    alloc_val   = issue;
    alloc_pc    = f_pc;
    alloc_waddr = rd;
  end

  // ----------------------------------------------------------
  // Register file and scoreboard
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      for (int i = 0; i < num_arch_regs; i++) begin
        rf[i] <= '0;
      end
    end else begin
      if (cmp0_val && cmp0_addr != '0) begin
        rf[cmp0_addr]      <= cmp0_data;
        pending[cmp0_addr] <= 1'b0;
      end
      if (cmp1_val && cmp1_addr != '0) begin
        rf[cmp1_addr]      <= cmp1_data;
        pending[cmp1_addr] <= 1'b0;
      end
      if (issue && rd != '0)
        pending[rd] <= 1'b1;  // New writer beats a same-cycle clear
    end
  end

  // A returning result always lands on a register still owed
  a_cmp0_was_pending: assert property (@(posedge clk) disable iff (rst)
    cmp0_val && cmp0_addr != '0 |-> pending[cmp0_addr]);

  a_cmp1_was_pending: assert property (@(posedge clk) disable iff (rst)
    cmp1_val && cmp1_addr != '0 |-> pending[cmp1_addr]);

endmodule

// File: verilog/fetch_unit.sv
// Needs an instruction memory that answers in the same cycle; no branches, the pc only steps by 4
`timescale 1ns/1ps

module fetch_unit (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [blimp_isa_pkg::inst_w-1:0] imem_data,
  input  logic                             d_stall,
  output logic [blimp_isa_pkg::xlen-1:0]   imem_addr,
  output logic                             f_val,
  output logic [blimp_isa_pkg::xlen-1:0]   f_pc,
  output logic [blimp_isa_pkg::inst_w-1:0] f_inst
);

  logic [blimp_isa_pkg::xlen-1:0] pc;

  assign imem_addr = pc;  // Memory model reads combinationally

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= '0;
      f_val <= 1'b0;
    end else if (!d_stall) begin
      pc    <= pc + 4;
      f_val <= 1'b1;  // Straight-line code, always something to hand over
    end
  end

  // F/D payload
  always_ff @(posedge clk) begin
    if (!d_stall) begin
      f_pc   <= pc;
      f_inst <= imem_data;
    end
  end

  // Memory must hand decode a clean word
  a_inst_known: assert property (@(posedge clk) disable iff (rst)
    f_val |-> !$isunknown(f_inst));

endmodule

// File: verilog/blimp_uarch_pkg.sv
// Sizes are fixed here; the reorder buffer depth must stay a power of two of seq_num_w
package blimp_uarch_pkg;

  localparam int seq_num_w  = 4;
  localparam int rob_depth  = 1 << seq_num_w;  // 16 entries, pointers wrap for free
  localparam int mul_stages = 4;               // Issue to x_val latency of the mul pipe

  // Execute pipes
  typedef enum logic {
    PIPE_ALU,
    PIPE_MUL
  } pipe_e;

endpackage

// File: verilog/blimp_isa_pkg.sv
// ISA subset is add, addi and mul only; any other opcode value is illegal and decodes as a nop
package blimp_isa_pkg;

  localparam int inst_w        = 32;
  localparam int xlen          = 32;  // Data and pc width
  localparam int reg_addr_w    = 5;
  localparam int num_arch_regs = 32;  // x0 hardwired to zero

  // ----------------------------------------------------------
  // Instruction field layout, given as lsb and width
  // ----------------------------------------------------------

  localparam int op_w    = 6;
  localparam int op_lsb  = 26;        // 31:26
  localparam int rd_lsb  = 21;        // 25:21
  localparam int rs1_lsb = 16;        // 20:16
  localparam int rs2_lsb = 11;        // 15:11
  localparam int imm_lsb = 0;
  localparam int imm_w   = 12;        // 11:0, overlaps rs2, sign-extended

  // Opcode field encodings
  // All-zero word is add x0,x0,x0
  typedef enum logic [op_w-1:0] {
    OP_ADD  = 6'h00,
    OP_ADDI = 6'h01,
    OP_MUL  = 6'h02
  } opcode_e;

endpackage
